// File: compile.f
design/frogger_pkg.sv
design/frog_control.sv
design/lane_scroller.sv
design/playfield.sv
design/max7219_driver.sv
design/frogger_top.sv
tests/tb_frogger.sv

// File: design/frog_control.sv
// Frog position
// Moves the frog one cell per button pulse while the game is running
`default_nettype none

module frog_control
	import frogger_pkg::*;
(
	input  logic        clock_50,
	input  logic        reset,
	input  logic        up_button,
	input  logic        down_button,
	input  logic        left_button,
	input  logic        right_button,
	input  play_state_t play_state,
	input  logic        restart,
	output idx_t        frog_row,
	output idx_t        frog_col
);

	// ====================
	// Position registers
	// ====================

	always_ff @(posedge clock_50) begin
		if (reset || restart) begin
			frog_row <= FROG_START_ROW;
			frog_col <= FROG_START_COL;
		end else if (play_state == ST_PLAY) begin
			// Up wins over down, down over left, left over right
			if (up_button) begin
				if (frog_row != 3'd7) begin
					frog_row <= frog_row + 3'd1;
				end
			end else if (down_button) begin
				if (frog_row != 3'd0) begin
					frog_row <= frog_row - 3'd1;
				end
			end else if (left_button) begin
				// Left walks toward column 7
				if (frog_col != 3'd7) begin
					frog_col <= frog_col + 3'd1;
				end
			end else if (right_button) begin
				if (frog_col != 3'd0) begin
					frog_col <= frog_col - 3'd1;
				end
			end
		end
	end

	// ====================
	// Checks
	// ====================

	// Frog is frozen outside play, except for a restart
	a_frozen_outside_play: assert property (@(posedge clock_50) disable iff (reset)
		((play_state != ST_PLAY) && !restart) |=> ($stable(frog_row) && $stable(frog_col)));

endmodule

`default_nettype wire

// File: design/frogger_pkg.sv
// Frogger shared definitions
// Matrix row types, game states, lane pattern and MAX7219 register map
`default_nettype none

package frogger_pkg;

	// ====================
	// Widths
	// ====================

	// One matrix row, bit i lights column i
	typedef logic [7:0] row_t;

	// Row or column index
	typedef logic [2:0] idx_t;

	// Serial word, address in the high byte
	typedef logic [15:0] max_word_t;

	// Game FSM
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PLAY,
		ST_LOST,
		ST_WON
	} play_state_t;

	// ====================
	// Game constants
	// ====================

	localparam idx_t FROG_START_ROW = 3'd0;
	localparam idx_t FROG_START_COL = 3'd4;

	// Background lanes, row 0 first
	localparam row_t LANE_PATTERN [8] = '{
		8'b00000000,
		8'b00000000,
		8'b11001100,
		8'b00000000,
		8'b00100100,
		8'b10001000,
		8'b00000000,
		8'b11011011
	};

	// ====================
	// MAX7219 registers
	// ====================

	localparam logic [7:0] MAX_REG_DECODE    = 8'h09;
	localparam logic [7:0] MAX_REG_INTENSITY = 8'h0A;
	localparam logic [7:0] MAX_REG_SCANLIMIT = 8'h0B;
	localparam logic [7:0] MAX_REG_SHUTDOWN  = 8'h0C;
	localparam logic [7:0] MAX_REG_TEST      = 8'h0F;

endpackage

`default_nettype wire

// File: design/frogger_top.sv
// Frogger top level
// Frog, lanes, playfield and MAX7219 driver wired together
`default_nettype none

module frogger_top
	import frogger_pkg::*;
#(
	parameter int         SCROLL_TICKS = 5000000,
	parameter int         CLK_DIV      = 4,
	parameter logic [3:0] INTENSITY    = 4'hA
) (
	input  logic        clock_50,
	input  logic        reset,
	input  logic        start_button,
	input  logic        up_button,
	input  logic        down_button,
	input  logic        left_button,
	input  logic        right_button,
	output logic        max7219_din,
	output logic        max7219_ncs,
	output logic        max7219_clk,
	output play_state_t play_state
);

	idx_t frog_row;
	idx_t frog_col;
	logic restart;
	idx_t row_sel;
	row_t row_bits;
	row_t lane0;
	row_t lane1;
	row_t lane2;
	row_t lane3;
	row_t lane4;
	row_t lane5;
	row_t lane6;
	row_t lane7;

	// ====================
	// Game
	// ====================

	frog_control u_frog_control (
		.clock_50     (clock_50),
		.reset        (reset),
		.up_button    (up_button),
		.down_button  (down_button),
		.left_button  (left_button),
		.right_button (right_button),
		.play_state   (play_state),
		.restart      (restart),
		.frog_row     (frog_row),
		.frog_col     (frog_col)
	);

	lane_scroller #(
		.SCROLL_TICKS (SCROLL_TICKS)
	) u_lane_scroller (
		.clock_50   (clock_50),
		.reset      (reset),
		.play_state (play_state),
		.restart    (restart),
		.lane0      (lane0),
		.lane1      (lane1),
		.lane2      (lane2),
		.lane3      (lane3),
		.lane4      (lane4),
		.lane5      (lane5),
		.lane6      (lane6),
		.lane7      (lane7)
	);

	playfield u_playfield (
		.clock_50     (clock_50),
		.reset        (reset),
		.start_button (start_button),
		.frog_row     (frog_row),
		.frog_col     (frog_col),
		.lane0        (lane0),
		.lane1        (lane1),
		.lane2        (lane2),
		.lane3        (lane3),
		.lane4        (lane4),
		.lane5        (lane5),
		.lane6        (lane6),
		.lane7        (lane7),
		.row_sel      (row_sel),
		.row_bits     (row_bits),
		.play_state   (play_state),
		.restart      (restart)
	);

	// ====================
	// Display
	// ====================

	max7219_driver #(
		.CLK_DIV   (CLK_DIV),
		.INTENSITY (INTENSITY)
	) u_max7219_driver (
		.clock_50    (clock_50),
		.reset       (reset),
		.row_bits    (row_bits),
		.row_sel     (row_sel),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

`default_nettype wire

// File: design/lane_scroller.sv
// Background lanes
// Eight lane registers, rotated every SCROLL_TICKS cycles while playing
`default_nettype none

module lane_scroller
	import frogger_pkg::*;
#(
	parameter int SCROLL_TICKS = 5000000
) (
	input  logic        clock_50,
	input  logic        reset,
	input  play_state_t play_state,
	input  logic        restart,
	output row_t        lane0,
	output row_t        lane1,
	output row_t        lane2,
	output row_t        lane3,
	output row_t        lane4,
	output row_t        lane5,
	output row_t        lane6,
	output row_t        lane7
);

	localparam int CNT_W = $clog2(SCROLL_TICKS + 1);

	logic [CNT_W-1:0] tick_cnt;
	logic             tick;
	row_t             lanes [8];

	// Last cycle of a scroll period
	assign tick = (tick_cnt == CNT_W'(SCROLL_TICKS - 1));

	// ====================
	// Lanes and prescaler
	// ====================

	always_ff @(posedge clock_50) begin
		if (reset || restart) begin
			tick_cnt <= '0;
			lanes    <= LANE_PATTERN;
		end else if (play_state == ST_PLAY) begin
			if (tick) begin
				tick_cnt <= '0;
				for (int i = 0; i < 8; i++) begin
					// Even lanes drift toward bit 7, odd ones toward bit 0
					if (i % 2 == 0) begin
						lanes[i] <= {lanes[i][6:0], lanes[i][7]};
					end else begin
						lanes[i] <= {lanes[i][0], lanes[i][7:1]};
					end
				end
			end else begin
				tick_cnt <= tick_cnt + CNT_W'(1);
			end
		end
	end

	assign lane0 = lanes[0];
	assign lane1 = lanes[1];
	assign lane2 = lanes[2];
	assign lane3 = lanes[3];
	assign lane4 = lanes[4];
	assign lane5 = lanes[5];
	assign lane6 = lanes[6];
	assign lane7 = lanes[7];

	// Rotation only moves cells, never adds or drops one
	for (genvar i = 0; i < 8; i++) begin : g_lane_chk
		a_rotation_keeps_cells: assert property (@(posedge clock_50) disable iff (reset)
			!restart |=> ($countones(lanes[i]) == $past($countones(lanes[i]))));
	end

endmodule

`default_nettype wire

// File: design/max7219_driver.sv
// MAX7219 serial driver
// Sends the init words once, then refreshes the eight digit rows forever
`default_nettype none

module max7219_driver
	import frogger_pkg::*;
#(
	parameter int         CLK_DIV   = 4,
	parameter logic [3:0] INTENSITY = 4'hA
) (
	input  logic clock_50,
	input  logic reset,
	input  row_t row_bits,
	output idx_t row_sel,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	localparam int DIV_W = $clog2(2 * CLK_DIV + 1);

	// Serial phase FSM
	typedef enum logic [1:0] {
		PH_GAP,
		PH_LOW,
		PH_HIGH
	} phase_t;

	phase_t           phase;
	logic [DIV_W-1:0] div_cnt;
	logic [3:0]       bit_cnt;
	max_word_t        shift_reg;
	max_word_t        word_now;
	logic [2:0]       init_idx;
	logic             init_done;
	logic             half_done;
	logic             gap_done;

	assign half_done = (div_cnt == DIV_W'(CLK_DIV - 1));
	assign gap_done  = (div_cnt == DIV_W'(2 * CLK_DIV - 1));

	// ====================
	// Word sequencer
	// ====================

	always_comb begin
		if (!init_done) begin
			case (init_idx)
				3'd0:    word_now = {MAX_REG_SHUTDOWN, 8'h01};
				3'd1:    word_now = {MAX_REG_DECODE, 8'h00};
				3'd2:    word_now = {MAX_REG_INTENSITY, 4'h0, INTENSITY};
				3'd3:    word_now = {MAX_REG_SCANLIMIT, 8'h07};
				default: word_now = {MAX_REG_TEST, 8'h00};
			endcase
		end else begin
			// Digit registers start at 1
			word_now = {8'(row_sel) + 8'd1, row_bits};
		end
	end

	// ====================
	// Serializer
	// ====================

	always_ff @(posedge clock_50) begin
		if (reset) begin
			phase       <= PH_GAP;
			div_cnt     <= '0;
			bit_cnt     <= '0;
			shift_reg   <= '0;
			init_idx    <= '0;
			init_done   <= 1'b0;
			row_sel     <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else begin
			case (phase)
				PH_GAP: begin
					if (gap_done) begin
						// Chip select falls and the word is latched
						div_cnt     <= '0;
						bit_cnt     <= '0;
						shift_reg   <= word_now;
						max7219_ncs <= 1'b0;
						phase       <= PH_LOW;
					end else begin
						div_cnt <= div_cnt + DIV_W'(1);
					end
				end
				PH_LOW: begin
					if (half_done) begin
						div_cnt     <= '0;
						max7219_clk <= 1'b1;
						phase       <= PH_HIGH;
					end else begin
						div_cnt <= div_cnt + DIV_W'(1);
					end
				end
				PH_HIGH: begin
					if (half_done) begin
						div_cnt     <= '0;
						max7219_clk <= 1'b0;
						if (bit_cnt == 4'd15) begin
							max7219_ncs <= 1'b1;
							phase       <= PH_GAP;
							// Next slot, rows wrap 7 to 0
							if (!init_done) begin
								init_done <= (init_idx == 3'd4);
								init_idx  <= init_idx + 3'd1;
							end else begin
								row_sel <= row_sel + 3'd1;
							end
						end else begin
							bit_cnt   <= bit_cnt + 4'd1;
							shift_reg <= shift_reg << 1;
							phase     <= PH_LOW;
						end
					end else begin
						div_cnt <= div_cnt + DIV_W'(1);
					end
				end
				default: phase <= PH_GAP;
			endcase
		end
	end

	// MSB first
	assign max7219_din = shift_reg[15];

	// No clock edges while the chip is deselected
	a_clk_idle_when_deselected: assert property (@(posedge clock_50) disable iff (reset)
		max7219_ncs |-> !max7219_clk);

endmodule

`default_nettype wire

// File: design/playfield.sv
// Playfield
// Builds the frame, detects collision and win, and runs the game FSM
`default_nettype none

module playfield
	import frogger_pkg::*;
(
	input  logic        clock_50,
	input  logic        reset,
	input  logic        start_button,
	input  idx_t        frog_row,
	input  idx_t        frog_col,
	input  row_t        lane0,
	input  row_t        lane1,
	input  row_t        lane2,
	input  row_t        lane3,
	input  row_t        lane4,
	input  row_t        lane5,
	input  row_t        lane6,
	input  row_t        lane7,
	input  idx_t        row_sel,
	output row_t        row_bits,
	output play_state_t play_state,
	output logic        restart
);

	row_t        lanes [8];
	row_t        frog_bit;
	logic        collision;
	logic        win;
	play_state_t state_next;

	assign lanes[0] = lane0;
	assign lanes[1] = lane1;
	assign lanes[2] = lane2;
	assign lanes[3] = lane3;
	assign lanes[4] = lane4;
	assign lanes[5] = lane5;
	assign lanes[6] = lane6;
	assign lanes[7] = lane7;

	// ====================
	// Frame and detection
	// ====================

	// One-hot frog column
	assign frog_bit = row_t'(1) << frog_col;

	// Row requested by the serial driver
	assign row_bits = lanes[row_sel] | ((row_sel == frog_row) ? frog_bit : '0);

	// Frog sitting on a lit cell of its own lane
	assign collision = |(lanes[frog_row] & frog_bit);
	assign win       = (frog_row == 3'd7) && !collision;

	// Start only counts when not already playing
	assign restart = start_button && (play_state != ST_PLAY);

	// ====================
	// Game FSM
	// ====================

	always_comb begin
		state_next = play_state;
		case (play_state)
			ST_IDLE, ST_LOST, ST_WON: begin
				if (restart) begin
					state_next = ST_PLAY;
				end
			end
			ST_PLAY: begin
				// A crash on the top row is still a loss
				if (collision) begin
					state_next = ST_LOST;
				end else if (win) begin
					state_next = ST_WON;
				end
			end
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock_50) begin
		if (reset) begin
			play_state <= ST_IDLE;
		end else begin
			play_state <= state_next;
		end
	end

	// End states wait for a new start
	a_end_state_held: assert property (@(posedge clock_50) disable iff (reset)
		((play_state inside {ST_LOST, ST_WON}) && !restart) |=> $stable(play_state));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_frogger -f compile.f -o tb_frogger

output=$(./obj_dir/tb_frogger) || true
echo "$output"

echo "$output" | grep -qx "RESULT: PASS"

// File: tests/tb_frogger.sv
// Frogger testbench
// Directed game tests, checked against frames captured from the MAX7219 link
`default_nettype none

module tb_frogger;
	import frogger_pkg::*;

	localparam int         SCROLL_TICKS = 3000;
	localparam int         CLK_DIV      = 2;
	localparam logic [3:0] INTENSITY    = 4'hA;
	// Clock_50 cycles per serial word with its gap
	localparam int WORD_CYCLES = 2 * CLK_DIV * 17;
	localparam int RUN_CYCLES  = 16 + 300 * WORD_CYCLES + 6 * SCROLL_TICKS;

	logic clock_50;
	logic reset;
	logic start_button;
	logic up_button;
	logic down_button;
	logic left_button;
	logic right_button;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;
	play_state_t play_state;

	frogger_top #(
		.SCROLL_TICKS (SCROLL_TICKS),
		.CLK_DIV      (CLK_DIV),
		.INTENSITY    (INTENSITY)
	) dut (
		.clock_50     (clock_50),
		.reset        (reset),
		.start_button (start_button),
		.up_button    (up_button),
		.down_button  (down_button),
		.left_button  (left_button),
		.right_button (right_button),
		.max7219_din  (max7219_din),
		.max7219_ncs  (max7219_ncs),
		.max7219_clk  (max7219_clk),
		.play_state   (play_state)
	);

	// Model state
	int   errors = 0;
	int   seed = 32'h2dfb90a7;
	int   play_edge = -1;
	int   stop_edge = 32'h7fffffff;
	bit   model_play = 1'b0;
	int   frog_r = 0;
	int   frog_c = 4;

	// Captured words with the edge on which chip select fell
	logic [15:0] word_q [$];
	int          start_q [$];
	logic [15:0] cur_word;
	int          cur_start;

	initial begin
		clock_50 = 1'b0;
		forever #50 clock_50 = ~clock_50;
	end

	// Index of the latest rising clock edge
	function automatic int edge_now();
		return int'(($time - 64'd50) / 64'd100);
	endfunction

	// ====================
	// Frame capture
	// ====================

	// One word per chip select, bits taken on the rising serial clock
	initial begin
		forever begin
			@(negedge max7219_ncs);
			cur_start = edge_now();
			for (int b = 0; b < 16; b++) begin
				@(posedge max7219_clk);
				cur_word = {cur_word[14:0], max7219_din};
			end
			word_q.push_back(cur_word);
			start_q.push_back(cur_start);
		end
	end

	// ====================
	// Reference model
	// ====================

	function automatic logic [7:0] rotated_lane(int row, int k);
		logic [7:0] v;
		v = LANE_PATTERN[row];
		for (int i = 0; i < k % 8; i++) begin
			if (row % 2 == 0) begin
				v = {v[6:0], v[7]};
			end else begin
				v = {v[0], v[7:1]};
			end
		end
		return v;
	endfunction

	// Rotations visible in row_bits just before edge e
	function automatic int lanes_rotation(int e);
		int last;
		if (play_edge < 0 || e <= play_edge) begin
			return 0;
		end
		last = (e - 1 < stop_edge) ? e - 1 : stop_edge;
		return (last - play_edge) / SCROLL_TICKS;
	endfunction

	function automatic logic [7:0] expected_row(int row, int e);
		logic [7:0] v;
		v = rotated_lane(row, lanes_rotation(e));
		if (row == frog_r) begin
			v[frog_c] = 1'b1;
		end
		return v;
	endfunction

	// Lane cell lit, false for a column off the matrix
	function automatic bit lit_at(logic [7:0] lane, int col);
		if (col < 0 || col > 7) begin
			return 1'b0;
		end
		return (lane[col] === 1'b1);
	endfunction

	// ====================
	// Checks
	// ====================

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// Drops the word in flight, then checks n full words
	task automatic check_words(string name, int n);
		int row;
		word_q.delete();
		start_q.delete();
		while (word_q.size() < n + 1) begin
			@(posedge clock_50);
		end
		for (int i = 1; i <= n; i++) begin
			row = int'(word_q[i][15:8]) - 1;
			check({name, " addr"}, 1, (row >= 0 && row <= 7) ? 1 : 0);
			check({name, " row"}, expected_row(row, start_q[i]), word_q[i][7:0]);
		end
	endtask

	// ====================
	// Stimulus
	// ====================

	// Direction 0 up, 1 down, 2 left, 3 right
	task automatic move(int dir);
		@(posedge clock_50);
		case (dir)
			0: up_button <= 1'b1;
			1: down_button <= 1'b1;
			2: left_button <= 1'b1;
			default: right_button <= 1'b1;
		endcase
		@(posedge clock_50);
		up_button <= 1'b0;
		down_button <= 1'b0;
		left_button <= 1'b0;
		right_button <= 1'b0;
		if (model_play) begin
			case (dir)
				0: frog_r = (frog_r < 7) ? frog_r + 1 : 7;
				1: frog_r = (frog_r > 0) ? frog_r - 1 : 0;
				2: frog_c = (frog_c < 7) ? frog_c + 1 : 7;
				default: frog_c = (frog_c > 0) ? frog_c - 1 : 0;
			endcase
		end
	endtask

	task automatic press_start();
		@(posedge clock_50);
		start_button <= 1'b1;
		@(posedge clock_50);
		start_button <= 1'b0;
		play_edge = edge_now();
		stop_edge = 32'h7fffffff;
		frog_r = FROG_START_ROW;
		frog_c = FROG_START_COL;
		model_play = 1'b1;
		#1;
		check("start", ST_PLAY, play_state);
	endtask

	task automatic move_to_col(int col);
		while (frog_c < col) move(2);
		while (frog_c > col) move(3);
	endtask

	// Nearest column reachable in lane r whose cell in lane r+1 is dark
	function automatic int find_col(int r, int col);
		logic [7:0] cur_lane;
		logic [7:0] next_lane;
		cur_lane = LANE_PATTERN[r];
		next_lane = LANE_PATTERN[r + 1];
		for (int d = 0; d < 8; d++) begin
			if (col + d <= 7 && cur_lane[col + d]) break;
			if (col + d <= 7 && !next_lane[col + d]) return col + d;
		end
		for (int d = 1; d < 8; d++) begin
			if (col - d < 0 || cur_lane[col - d]) break;
			if (!next_lane[col - d]) return col - d;
		end
		return -1;
	endfunction

	// ====================
	// Tests
	// ====================

	task automatic init_sequence();
		logic [15:0] init_words [5];
		init_words = '{16'h0C01, 16'h0900, {12'h0A0, INTENSITY}, 16'h0B07, 16'h0F00};
		check("reset state", ST_IDLE, play_state);
		while (word_q.size() < 13) @(posedge clock_50);
		for (int i = 0; i < 5; i++) begin
			check("init word", init_words[i], word_q[i]);
		end
		for (int r = 0; r < 8; r++) begin
			check("first frame addr", r + 1, word_q[5 + r][15:8]);
			check("first frame row", expected_row(r, start_q[5 + r]), word_q[5 + r][7:0]);
		end
	endtask

	task automatic idle_and_clamp();
		move(0);
		move(2);
		check_words("idle moves", 8);
		press_start();
		repeat (5) move(2);
		move(1);
		check_words("clamp left", 8);
		repeat (9) move(3);
		check_words("clamp right", 8);
	endtask

	task automatic lane_scroll();
		move_to_col($unsigned($random(seed)) % 8);
		check_words("scroll", 3 * SCROLL_TICKS / WORD_CYCLES);
	endtask

	task automatic crash_into_lane();
		int k;
		int s;
		logic [7:0] lane;
		move(0);
		// Line up under a lit cell of lane 2 for the edge that checks it
		for (int i = 0; i < 20; i++) begin
			lane = rotated_lane(2, lanes_rotation(edge_now() + 3));
			if (lane[frog_c]) break;
			// Nearest lit cell inside the matrix, the frog cannot wrap
			k = 1;
			while (k < 8 && !lit_at(lane, frog_c + k) && !lit_at(lane, frog_c - k)) begin
				k++;
			end
			move(lit_at(lane, frog_c + k) ? 2 : 3);
		end
		@(posedge clock_50);
		up_button <= 1'b1;
		@(posedge clock_50);
		up_button <= 1'b0;
		s = edge_now();
		frog_r = 2;
		#1;
		check("collision edge 1", ST_PLAY, play_state);
		@(posedge clock_50);
		#1;
		check("collision edge 2", ST_LOST, play_state);
		stop_edge = s + 1;
		model_play = 1'b0;
		move(0);
		move(3);
		check("lost held", ST_LOST, play_state);
		check_words("lost frame", 8);
	endtask

	task automatic restart_from_lost();
		press_start();
		check_words("restart frame", 8);
	endtask

	task automatic path_to_top();
		int t;
		int s;
		for (int r = 0; r < 7; r++) begin
			t = find_col(r, frog_c);
			if (t < 0) begin
				report_failure("no path through the lanes was found");
			end
			move_to_col(t);
			if (r < 6) begin
				move(0);
			end
		end
		@(posedge clock_50);
		up_button <= 1'b1;
		@(posedge clock_50);
		up_button <= 1'b0;
		s = edge_now();
		frog_r = 7;
		if (lanes_rotation(s + 1) != 0) begin
			report_failure("path took longer than one scroll period");
		end
		#1;
		check("win edge 1", ST_PLAY, play_state);
		@(posedge clock_50);
		#1;
		check("win edge 2", ST_WON, play_state);
		stop_edge = s + 1;
		model_play = 1'b0;
		move(1);
		check("won held", ST_WON, play_state);
		check_words("won frame", 8);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		reset = 1'b1;
		start_button = 1'b0;
		up_button = 1'b0;
		down_button = 1'b0;
		left_button = 1'b0;
		right_button = 1'b0;
		repeat (16) @(posedge clock_50);
		reset <= 1'b0;
		@(posedge clock_50);
		#1;
		init_sequence();
		idle_and_clamp();
		lane_scroll();
		crash_into_lane();
		restart_from_lost();
		path_to_top();
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (RUN_CYCLES) @(posedge clock_50);
		report_failure("timeout: the tests did not finish in time");
	end

endmodule

`default_nettype wire
